//--- Bender.yml
package:
  name: dma_read

sources:
  - hdl/dma_pkg.sv
  - hdl/dma_cfg_regs.sv
  - hdl/burst_len_ctr.sv
  - hdl/read_merge.sv
  - hdl/axi_burst_reader.sv
  - hdl/dma_read_top.sv
  - target: test
    files:
      - dv/tb_clkgen.sv
      - dv/dma_read_tb.sv

//--- compile.f
hdl/dma_pkg.sv
hdl/dma_cfg_regs.sv
hdl/burst_len_ctr.sv
hdl/read_merge.sv
hdl/axi_burst_reader.sv
hdl/dma_read_top.sv
dv/tb_clkgen.sv
dv/dma_read_tb.sv

//--- dv/dma_read_tb.sv
`timescale 1ns/10ps
`default_nettype none

module dma_read_tb;

	import dma_pkg::*;

	localparam int timeout_cycles = 5000;
	localparam word_t data_mask = 32'ha5a5_0000;

	logic clk;
	logic rst;
	logic clear;
	logic run;
	logic valid;
	cpu_addr_t addr;
	word_t wdata;
	logic wstrb;
	logic [n_rd_ports-1:0] databus_valid;
	ddr_addr_t [n_rd_ports-1:0] databus_addr;
	word_t [n_rd_ports-1:0] databus_rdata;
	logic [n_rd_ports-1:0] databus_ready;
	ddr_addr_t m_axi_araddr;
	axi_len_t m_axi_arlen;
	logic m_axi_arvalid;
	logic m_axi_arready;
	word_t m_axi_rdata;
	logic m_axi_rlast;
	logic m_axi_rvalid;
	logic m_axi_rready;

	integer seed = 32'he3f0;

	// model of the length registers and counters
	xfer_cnt_t live_len [n_rd_ports];
	xfer_cnt_t shadow_len [n_rd_ports];
	xfer_cnt_t cnt_len [n_rd_ports];

	// per-port progress, counted by the monitor
	ddr_addr_t port_start [n_rd_ports];
	int port_got [n_rd_ports];
	int port_want [n_rd_ports];

	ddr_addr_t ar_addr_seen [$];
	axi_len_t ar_len_seen [$];
	ddr_addr_t ar_addr_exp [$];
	axi_len_t ar_len_exp [$];

	// scenario table, one entry per row
	logic [n_rd_ports-1:0] t_wr_mask [$];
	logic t_bad [$];
	logic t_run [$];
	logic t_clear [$];
	xfer_cnt_t [n_rd_ports-1:0] t_len [$];
	ddr_addr_t [n_rd_ports-1:0] t_addr [$];
	logic [n_rd_ports-1:0] t_req [$];

	tb_clkgen u_tb_clkgen (
		.clk(clk),
		.rst(rst)
	);

	dma_read_top u_dma_read_top (
		.clk(clk),
		.rst(rst),
		.clear(clear),
		.run(run),
		.valid(valid),
		.addr(addr),
		.wdata(wdata),
		.wstrb(wstrb),
		.databus_valid(databus_valid),
		.databus_addr(databus_addr),
		.databus_rdata(databus_rdata),
		.databus_ready(databus_ready),
		.m_axi_araddr(m_axi_araddr),
		.m_axi_arlen(m_axi_arlen),
		.m_axi_arvalid(m_axi_arvalid),
		.m_axi_arready(m_axi_arready),
		.m_axi_rdata(m_axi_rdata),
		.m_axi_rlast(m_axi_rlast),
		.m_axi_rvalid(m_axi_rvalid),
		.m_axi_rready(m_axi_rready)
	);

	task automatic abort_run();
		$display("TESTBENCH FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic report_error(string msg);
		$display("ERROR %s", msg);
		abort_run();
	endtask

	task automatic check_word(string name, word_t got, word_t exp);
		if (got !== exp) begin
			$display("FAIL %s got %h expected %h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_len(string name, axi_len_t got, axi_len_t exp);
		if (got !== exp) begin
			$display("FAIL %s got %h expected %h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_addr(string name, ddr_addr_t got, ddr_addr_t exp);
		if (got !== exp) begin
			$display("FAIL %s got %h expected %h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_flag(string name, logic got, logic exp);
		if (got !== exp) begin
			$display("FAIL %s got %h expected %h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic add_row(logic [n_rd_ports-1:0] wr_mask, logic bad, logic do_run,
			logic do_clear, xfer_cnt_t len0, xfer_cnt_t len1, ddr_addr_t addr0,
			ddr_addr_t addr1, logic [n_rd_ports-1:0] req);
		t_wr_mask.push_back(wr_mask);
		t_bad.push_back(bad);
		t_run.push_back(do_run);
		t_clear.push_back(do_clear);
		t_len.push_back({len1, len0});
		t_addr.push_back({addr1, addr0});
		t_req.push_back(req);
	endtask

	task automatic build_table();
		add_row(2'b01, 1'b0, 1'b1, 1'b0, 16'd3, 16'd0, 32'h0000_1000, 32'h0, 2'b01);
		add_row(2'b10, 1'b0, 1'b1, 1'b0, 16'd0, 16'd20, 32'h0, 32'h0000_2040, 2'b10);
		add_row(2'b01, 1'b0, 1'b1, 1'b0, 16'd300, 16'd0, 32'h0000_4000, 32'h0, 2'b01);
		add_row(2'b11, 1'b0, 1'b1, 1'b0, 16'd5, 16'd7, 32'h0000_5000, 32'h0000_6000, 2'b11);
		// clear right after run
		add_row(2'b01, 1'b0, 1'b1, 1'b1, 16'd12, 16'd0, 32'h0000_7000, 32'h0, 2'b01);
		// no run, counter rearmed from the shadow
		add_row(2'b00, 1'b0, 1'b0, 1'b0, 16'd0, 16'd0, 32'h0000_7400, 32'h0, 2'b01);
		// run with no write, cleared lengths give single words
		add_row(2'b00, 1'b0, 1'b1, 1'b0, 16'd0, 16'd0, 32'h0000_7800, 32'h0, 2'b01);
		add_row(2'b11, 1'b1, 1'b1, 1'b0, 16'd40, 16'd2, 32'h0000_8000, 32'h0000_9000, 2'b11);
		add_row(2'b10, 1'b0, 1'b1, 1'b0, 16'd0, 16'd600, 32'h0, 32'h0000_a000, 2'b10);
	endtask

	task automatic cpu_write(cpu_addr_t a, word_t d);
		@(posedge clk);
		#1;
		valid = 1'b1;
		wstrb = 1'b1;
		addr = a;
		wdata = d;
		@(posedge clk);
		#1;
		valid = 1'b0;
		wstrb = 1'b0;
		case (a)
			reg_len0: live_len[0] = d[cnt_w-1:0];
			reg_len1: live_len[1] = d[cnt_w-1:0];
			default: ;
		endcase
	endtask

	task automatic pulse_run();
		@(posedge clk);
		#1;
		run = 1'b1;
		@(posedge clk);
		#1;
		run = 1'b0;
		shadow_len = live_len;
		cnt_len = live_len;
	endtask

	task automatic pulse_clear();
		@(posedge clk);
		#1;
		clear = 1'b1;
		@(posedge clk);
		#1;
		clear = 1'b0;
		for (int p = 0; p < n_rd_ports; p++) begin
			live_len[p] = '0;
		end
	endtask

	// bursts of at most 256 beats, 1024 bytes apart
	task automatic add_bursts(ddr_addr_t start, xfer_cnt_t cnt);
		int rem;
		ddr_addr_t a;
		rem = int'(cnt);
		a = start;
		do begin
			ar_addr_exp.push_back(a);
			ar_len_exp.push_back((rem > 255) ? axi_len_t'(255) : axi_len_t'(rem));
			rem = rem - 256;
			a = a + 32'd1024;
		end while (rem >= 0);
	endtask

	task automatic serve_port(int p);
		int cycles;
		cycles = 0;
		@(posedge clk);
		#1;
		databus_addr[p] = port_start[p];
		databus_valid[p] = 1'b1;
		while (port_got[p] < port_want[p]) begin
			@(posedge clk);
			#1;
			// next burst starts past the last word received
			if (port_got[p] % 256 == 0) begin
				databus_addr[p] = port_start[p] + ddr_addr_t'(4 * port_got[p]);
			end
			cycles++;
			if (cycles >= timeout_cycles) begin
				report_error($sformatf("port %0d did not receive all its words in %0d cycles",
					p, timeout_cycles));
			end
		end
		databus_valid[p] = 1'b0;
	endtask

	task automatic run_row(int r);
		ar_addr_seen.delete();
		ar_len_seen.delete();
		ar_addr_exp.delete();
		ar_len_exp.delete();
		if (t_wr_mask[r][0]) cpu_write(reg_len0, word_t'(t_len[r][0]));
		if (t_wr_mask[r][1]) cpu_write(reg_len1, word_t'(t_len[r][1]));
		// unmapped address, must be ignored
		if (t_bad[r]) cpu_write(cpu_addr_t'(6), 32'h0000_01ff);
		if (t_run[r]) pulse_run();
		if (t_clear[r]) pulse_clear();
		for (int p = 0; p < n_rd_ports; p++) begin
			port_got[p] = 0;
			port_start[p] = t_addr[r][p];
			port_want[p] = t_req[r][p] ? int'(cnt_len[p]) + 1 : 0;
			if (t_req[r][p]) add_bursts(t_addr[r][p], cnt_len[p]);
		end
		fork
			if (t_req[r][0]) serve_port(0);
			if (t_req[r][1]) serve_port(1);
		join
		for (int p = 0; p < n_rd_ports; p++) begin
			if (t_req[r][p]) cnt_len[p] = shadow_len[p];
		end
		if (ar_addr_seen.size() != ar_addr_exp.size()) begin
			report_error($sformatf("row %0d expected %0d AR bursts but saw %0d",
				r, ar_addr_exp.size(), ar_addr_seen.size()));
		end
		for (int i = 0; i < ar_addr_exp.size(); i++) begin
			check_addr("m_axi_araddr", ar_addr_seen[i], ar_addr_exp[i]);
			check_len("m_axi_arlen", ar_len_seen[i], ar_len_exp[i]);
		end
		repeat (4) @(posedge clk);
	endtask

	// AXI read slave with random stalls
	initial begin : axi_slave
		logic ar_fire;
		logic r_fire;
		ddr_addr_t ar_addr_s;
		axi_len_t ar_len_s;
		logic rd_active;
		ddr_addr_t rd_addr;
		int rd_left;
		m_axi_arready = 1'b0;
		m_axi_rvalid = 1'b0;
		m_axi_rlast = 1'b0;
		m_axi_rdata = '0;
		rd_active = 1'b0;
		rd_addr = '0;
		rd_left = 0;
		forever begin
			@(negedge clk);
			ar_fire = m_axi_arvalid && m_axi_arready;
			r_fire = m_axi_rvalid && m_axi_rready;
			ar_addr_s = m_axi_araddr;
			ar_len_s = m_axi_arlen;
			@(posedge clk);
			#1;
			if (r_fire) begin
				rd_addr = rd_addr + 32'd4;
				rd_left--;
				rd_active = (rd_left > 0);
			end
			if (ar_fire) begin
				rd_active = 1'b1;
				rd_addr = ar_addr_s;
				rd_left = int'(ar_len_s) + 1;
			end
			m_axi_arready = !rd_active && (($random(seed) & 3) != 0);
			// a beat not yet taken stays on the bus
			if (!(m_axi_rvalid && !r_fire)) begin
				m_axi_rvalid = rd_active && (($random(seed) & 3) != 0);
			end
			m_axi_rdata = rd_addr ^ data_mask;
			m_axi_rlast = rd_active && (rd_left == 1);
		end
	end

	// mid-cycle checks of the AR channel and the port responses
	initial begin : monitor
		logic ar_held;
		ddr_addr_t held_addr;
		axi_len_t held_len;
		word_t exp_word;
		ar_held = 1'b0;
		forever begin
			@(negedge clk);
			if (ar_held) begin
				check_flag("m_axi_arvalid", m_axi_arvalid, 1'b1);
				check_addr("m_axi_araddr", m_axi_araddr, held_addr);
				check_len("m_axi_arlen", m_axi_arlen, held_len);
			end
			ar_held = m_axi_arvalid && !m_axi_arready;
			held_addr = m_axi_araddr;
			held_len = m_axi_arlen;
			if (m_axi_arvalid && m_axi_arready) begin
				ar_addr_seen.push_back(m_axi_araddr);
				ar_len_seen.push_back(m_axi_arlen);
			end
			if ($countones(databus_ready) > 1) begin
				report_error("ready went to more than one port in the same cycle");
			end
			for (int p = 0; p < n_rd_ports; p++) begin
				if (databus_ready[p]) begin
					if (!databus_valid[p] || port_got[p] >= port_want[p]) begin
						report_error($sformatf("port %0d got a word it did not ask for", p));
					end
					if (p > 0 && port_got[0] < port_want[0]) begin
						report_error("port 1 got a word before port 0 finished");
					end
					exp_word = (port_start[p] + ddr_addr_t'(4 * port_got[p])) ^ data_mask;
					check_word($sformatf("databus_rdata[%0d]", p), databus_rdata[p], exp_word);
					port_got[p]++;
				end
			end
		end
	end

	initial begin : stimulus
		int cycles;
		clear = 1'b0;
		run = 1'b0;
		valid = 1'b0;
		addr = '0;
		wdata = '0;
		wstrb = 1'b0;
		databus_valid = '0;
		databus_addr = '0;
		for (int p = 0; p < n_rd_ports; p++) begin
			live_len[p] = '0;
			shadow_len[p] = '0;
			cnt_len[p] = '0;
			port_start[p] = '0;
			port_got[p] = 0;
			port_want[p] = 0;
		end
		build_table();
		cycles = 0;
		while (rst !== 1'b0) begin
			@(posedge clk);
			cycles++;
			if (cycles >= timeout_cycles) report_error("reset was never released");
		end
		#1;
		check_flag("m_axi_arvalid", m_axi_arvalid, 1'b0);
		check_flag("m_axi_rready", m_axi_rready, 1'b0);
		check_flag("databus_ready[0]", databus_ready[0], 1'b0);
		check_flag("databus_ready[1]", databus_ready[1], 1'b0);
		// quiet period, no port asking
		repeat (20) @(posedge clk);
		if (ar_addr_seen.size() != 0) report_error("an AR burst was issued with no port valid");
		for (int r = 0; r < t_req.size(); r++) begin
			run_row(r);
		end
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- dv/tb_clkgen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clkgen (
	output logic clk,
	output logic rst
);

	localparam int half_period = 5;
	localparam int rst_cycles = 4;

	initial begin
		clk = 1'b0;
		forever #half_period clk = ~clk;
	end

	// release just after an edge, like the other inputs
	initial begin
		rst = 1'b1;
		repeat (rst_cycles) @(posedge clk);
		#1;
		rst = 1'b0;
	end

endmodule

`default_nettype wire

//--- hdl/axi_burst_reader.sv
`timescale 1ns/10ps
`default_nettype none

module axi_burst_reader (
	input logic clk,
	input logic rst,
	input logic valid,
	input dma_pkg::ddr_addr_t addr,
	input dma_pkg::axi_len_t len,
	output dma_pkg::word_t rdata,
	output logic ready,
	output logic burst_done,
	output dma_pkg::ddr_addr_t m_axi_araddr,
	output dma_pkg::axi_len_t m_axi_arlen,
	output logic m_axi_arvalid,
	input logic m_axi_arready,
	input dma_pkg::word_t m_axi_rdata,
	input logic m_axi_rlast,
	input logic m_axi_rvalid,
	output logic m_axi_rready
);

	import dma_pkg::*;

	rd_state_e state;
	ddr_addr_t addr_q;
	axi_len_t len_q;
	logic beat;

	// one burst at a time
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle: begin
					if (valid) begin
						state <= st_addr;
					end
				end
				st_addr: begin
					if (m_axi_arready) begin
						state <= st_data;
					end
				end
				st_data: begin
					if (beat && m_axi_rlast) begin
						state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// burst request captured when leaving idle
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			addr_q <= '0;
			len_q <= '0;
		end else if (state == st_idle && valid) begin
			addr_q <= addr;
			len_q <= len;
		end
	end

	// address channel, fields stable while arvalid is up
	assign m_axi_arvalid = (state == st_addr);
	assign m_axi_araddr = addr_q;
	assign m_axi_arlen = len_q;

	// data channel passes straight through to the port
	assign m_axi_rready = (state == st_data);
	assign beat = m_axi_rready && m_axi_rvalid;
	assign ready = beat;
	assign rdata = m_axi_rdata;
	assign burst_done = beat && m_axi_rlast;

endmodule

`default_nettype wire

//--- hdl/burst_len_ctr.sv
`timescale 1ns/10ps
`default_nettype none

module burst_len_ctr (
	input logic clk,
	input logic rst,
	input logic run,
	input logic ready,
	input dma_pkg::xfer_cnt_t len_cfg,
	input dma_pkg::xfer_cnt_t len_shadow,
	output dma_pkg::axi_len_t burst_len
);

	import dma_pkg::*;

	xfer_cnt_t cnt;
	logic over_max;

	// words still owed to this port, minus one
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			cnt <= '0;
		end else if (run) begin
			cnt <= len_cfg;
		end else if (ready) begin
			if (cnt == '0) begin
				// transfer done, rearm for the next one
				cnt <= len_shadow;
			end else begin
				cnt <= cnt - 1'b1;
			end
		end
	end

	// cap at 256 beats per burst
	assign over_max = |cnt[cnt_w-1:axi_len_w];
	assign burst_len = over_max ? '1 : cnt[axi_len_w-1:0];

endmodule

`default_nettype wire

//--- hdl/dma_cfg_regs.sv
`timescale 1ns/10ps
`default_nettype none

module dma_cfg_regs (
	input logic clk,
	input logic rst,
	input logic clear,
	input logic run,
	input logic valid,
	input logic wstrb,
	input dma_pkg::cpu_addr_t addr,
	input dma_pkg::word_t wdata,
	output dma_pkg::xfer_cnt_t [dma_pkg::n_rd_ports-1:0] len_cfg,
	output dma_pkg::xfer_cnt_t [dma_pkg::n_rd_ports-1:0] len_shadow
);

	import dma_pkg::*;

	logic [n_rd_ports-1:0] wr_en;

	// address decode, one enable per port length
	always_comb begin
		wr_en = '0;
		if (valid && wstrb) begin
			case (cfg_reg_e'(addr))
				reg_len0: wr_en[0] = 1'b1;
				reg_len1: wr_en[1] = 1'b1;
				default: wr_en = '0;
			endcase
		end
	end

	// live lengths, written by the cpu
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			len_cfg <= '0;
		end else if (clear) begin
			len_cfg <= '0;
		end else begin
			for (int i = 0; i < n_rd_ports; i++) begin
				if (wr_en[i]) begin
					len_cfg[i] <= wdata[cnt_w-1:0];
				end
			end
		end
	end

	// shadow copies used for counter reload, untouched by clear
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			len_shadow <= '0;
		end else if (run) begin
			len_shadow <= len_cfg;
		end
	end

endmodule

`default_nettype wire

//--- hdl/dma_pkg.sv
`default_nettype none

package dma_pkg;

	// read port count and bus widths
	localparam int n_rd_ports = 2;
	localparam int word_w = 32;
	localparam int ddr_addr_w = 32;
	localparam int cpu_addr_w = 4;
	localparam int axi_len_w = 8;
	localparam int cnt_w = 16;

	// width of a port index in the merge
	localparam int port_idx_w = (n_rd_ports > 1) ? $clog2(n_rd_ports) : 1;

	typedef logic [word_w-1:0] word_t;
	typedef logic [ddr_addr_w-1:0] ddr_addr_t;
	typedef logic [cpu_addr_w-1:0] cpu_addr_t;
	typedef logic [axi_len_w-1:0] axi_len_t;
	typedef logic [cnt_w-1:0] xfer_cnt_t;
	typedef logic [port_idx_w-1:0] port_idx_t;

	// cpu register map, one length per read port
	typedef enum cpu_addr_t {
		reg_len0 = cpu_addr_t'(0),
		reg_len1 = cpu_addr_t'(1)
	} cfg_reg_e;

	// burst reader states
	typedef enum logic [1:0] {
		st_idle,
		st_addr,
		st_data
	} rd_state_e;

endpackage

`default_nettype wire

//--- hdl/dma_read_top.sv
`timescale 1ns/10ps
`default_nettype none

module dma_read_top (
	input logic clk,
	input logic rst,
	input logic clear,
	input logic run,
	input logic valid,
	input dma_pkg::cpu_addr_t addr,
	input dma_pkg::word_t wdata,
	input logic wstrb,
	input logic [dma_pkg::n_rd_ports-1:0] databus_valid,
	input dma_pkg::ddr_addr_t [dma_pkg::n_rd_ports-1:0] databus_addr,
	output dma_pkg::word_t [dma_pkg::n_rd_ports-1:0] databus_rdata,
	output logic [dma_pkg::n_rd_ports-1:0] databus_ready,
	output dma_pkg::ddr_addr_t m_axi_araddr,
	output dma_pkg::axi_len_t m_axi_arlen,
	output logic m_axi_arvalid,
	input logic m_axi_arready,
	input dma_pkg::word_t m_axi_rdata,
	input logic m_axi_rlast,
	input logic m_axi_rvalid,
	output logic m_axi_rready
);

	import dma_pkg::*;

	xfer_cnt_t [n_rd_ports-1:0] len_cfg;
	xfer_cnt_t [n_rd_ports-1:0] len_shadow;
	axi_len_t [n_rd_ports-1:0] burst_len;

	// merged request towards the reader
	logic s_valid;
	ddr_addr_t s_addr;
	axi_len_t s_len;
	word_t s_rdata;
	logic s_ready;
	logic s_done;

	dma_cfg_regs u_dma_cfg_regs (
		.clk(clk),
		.rst(rst),
		.clear(clear),
		.run(run),
		.valid(valid),
		.wstrb(wstrb),
		.addr(addr),
		.wdata(wdata),
		.len_cfg(len_cfg),
		.len_shadow(len_shadow)
	);

	// one length counter per read port
	for (genvar i = 0; i < n_rd_ports; i++) begin : g_len_ctr
		burst_len_ctr u_burst_len_ctr (
			.clk(clk),
			.rst(rst),
			.run(run),
			.ready(databus_ready[i]),
			.len_cfg(len_cfg[i]),
			.len_shadow(len_shadow[i]),
			.burst_len(burst_len[i])
		);
	end

	read_merge u_read_merge (
		.clk(clk),
		.rst(rst),
		.m_valid(databus_valid),
		.m_addr(databus_addr),
		.m_len(burst_len),
		.m_rdata(databus_rdata),
		.m_ready(databus_ready),
		.s_valid(s_valid),
		.s_addr(s_addr),
		.s_len(s_len),
		.s_rdata(s_rdata),
		.s_ready(s_ready),
		.s_done(s_done)
	);

	axi_burst_reader u_axi_burst_reader (
		.clk(clk),
		.rst(rst),
		.valid(s_valid),
		.addr(s_addr),
		.len(s_len),
		.rdata(s_rdata),
		.ready(s_ready),
		.burst_done(s_done),
		.m_axi_araddr(m_axi_araddr),
		.m_axi_arlen(m_axi_arlen),
		.m_axi_arvalid(m_axi_arvalid),
		.m_axi_arready(m_axi_arready),
		.m_axi_rdata(m_axi_rdata),
		.m_axi_rlast(m_axi_rlast),
		.m_axi_rvalid(m_axi_rvalid),
		.m_axi_rready(m_axi_rready)
	);

endmodule

`default_nettype wire

//--- hdl/read_merge.sv
`timescale 1ns/10ps
`default_nettype none

module read_merge (
	input logic clk,
	input logic rst,
	input logic [dma_pkg::n_rd_ports-1:0] m_valid,
	input dma_pkg::ddr_addr_t [dma_pkg::n_rd_ports-1:0] m_addr,
	input dma_pkg::axi_len_t [dma_pkg::n_rd_ports-1:0] m_len,
	output dma_pkg::word_t [dma_pkg::n_rd_ports-1:0] m_rdata,
	output logic [dma_pkg::n_rd_ports-1:0] m_ready,
	output logic s_valid,
	output dma_pkg::ddr_addr_t s_addr,
	output dma_pkg::axi_len_t s_len,
	input dma_pkg::word_t s_rdata,
	input logic s_ready,
	input logic s_done
);

	import dma_pkg::*;

	logic busy;
	port_idx_t grant;
	port_idx_t next_idx;

	// lowest requesting index wins
	always_comb begin
		next_idx = '0;
		for (int i = n_rd_ports - 1; i >= 0; i--) begin
			if (m_valid[i]) begin
				next_idx = port_idx_t'(i);
			end
		end
	end

	// grant held for a whole burst
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			busy <= 1'b0;
			grant <= '0;
		end else if (!busy) begin
			if (|m_valid) begin
				busy <= 1'b1;
				grant <= next_idx;
			end
		end else if (s_done) begin
			busy <= 1'b0;
		end
	end

	// request path to the reader
	assign s_valid = busy && m_valid[grant];
	assign s_addr = m_addr[grant];
	assign s_len = m_len[grant];

	// response path, granted port only
	always_comb begin
		for (int i = 0; i < n_rd_ports; i++) begin
			if (busy && grant == port_idx_t'(i)) begin
				m_ready[i] = s_ready;
				m_rdata[i] = s_rdata;
			end else begin
				m_ready[i] = 1'b0;
				m_rdata[i] = '0;
			end
		end
	end

endmodule

`default_nettype wire
